// ==== verilog/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

	// Instruction word layout
	// [15:14] group, [13:10] opcode, [9:8] arg A, [7:4] arg B, [3:0] mode
	typedef logic [15:0] instrT;
	typedef logic [1:0]  groupT;
	typedef logic [3:0]  aluOpT;       // Also the raw opcode field
	typedef logic [3:0]  argT;
	typedef logic [1:0]  sel2T;
	typedef logic [2:0]  sel3T;
	typedef logic [3:0]  seqT;         // Register sequencer code

	// Instruction groups
	localparam groupT GROUP_SYSTEM           = 2'd0;
	localparam groupT GROUP_LOAD_STORE       = 2'd1;
	localparam groupT GROUP_JUMP             = 2'd2;
	localparam groupT GROUP_ARITHMETIC_LOGIC = 2'd3;

	// ALU operations the decoder treats specially
	localparam aluOpT ALU_OPX_MOV = 4'd0;
	localparam aluOpT ALU_OPX_CMP = 4'd7;

	// Register sequences
	localparam seqT REG_SEQX_NONE    = 4'd0;
	localparam seqT REG_SEQX_WRITE_A = 4'd1;
	localparam seqT REG_SEQX_READ_AB = 4'd2;

	// Address bus source
	localparam sel3T ADDR_BUSX_PC_A  = 3'd0;
	localparam sel3T ADDR_BUSX_DEBUG = 3'd1;
	localparam sel3T ADDR_BUSX_REG_B = 3'd2;

	// ALU operand sources
	localparam sel3T ALUA_SRCX_REG_A = 3'd0;
	localparam sel3T ALUB_SRCX_REG_B = 3'd0;
	localparam sel3T ALUB_SRCX_IMM   = 3'd1;

	// Bus sequencer requests
	localparam sel2T BUS_SEQX_NONE  = 2'd0;
	localparam sel2T BUS_SEQX_READ  = 2'd1;
	localparam sel2T BUS_SEQX_WRITE = 2'd2;

	localparam logic BYTEX_WORD = 1'b0;  // Full 16-bit transfer

	// Data bus driver
	localparam sel2T DATA_BUSX_REGA_DOUT = 2'd0;
	localparam sel2T DATA_BUSX_ALU_R     = 2'd1;

	// Program counter adder
	localparam sel2T PC_BASEX_PC_A    = 2'd0;
	localparam sel2T PC_BASEX_REG_B   = 2'd1;
	localparam sel2T PC_OFFSETX_2     = 2'd0;
	localparam sel2T PC_OFFSETX_IMM   = 2'd1;

	// Register file ports
	localparam sel2T REGA_ADDRX_ARGA  = 2'd0;
	localparam sel2T REGA_DINX_DIN    = 2'd0;
	localparam sel2T REGA_DINX_ALU_R  = 2'd1;
	localparam sel2T REGA_DINX_PC     = 2'd2;  // Return address for calls
	localparam sel3T REGB_ADDRX_ARGB  = 3'd0;

endpackage

// ==== verilog/ctrlFieldsIf.sv ====
`timescale 1ns/1ps

// One candidate set of control fields from a group decoder
interface ctrlFieldsIf;
	import cpuCtrlPkg::*;

	sel3T  addrBus;
	aluOpT aluOp;
	sel3T  aluaSrc;
	sel3T  alubSrc;
	sel2T  busSeq;
	logic  byteX;
	logic  cclLd;
	sel2T  dataBus;
	sel2T  pcBase;
	sel2T  pcOffset;
	seqT   regSeq;
	sel2T  regaAddr;
	sel2T  regaDin;
	sel3T  regbAddr;

	modport src (
		output addrBus, aluOp, aluaSrc, alubSrc, busSeq, byteX, cclLd,
		output dataBus, pcBase, pcOffset, regSeq, regaAddr, regaDin, regbAddr
	);

	// Result stage side
	modport sink (
		input addrBus, aluOp, aluaSrc, alubSrc, busSeq, byteX, cclLd,
		input dataBus, pcBase, pcOffset, regSeq, regaAddr, regaDin, regbAddr
	);

endinterface

// ==== verilog/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode import cpuCtrlPkg::*; #(
	parameter int INSTR_W = 16
) (
	input  logic               clk,
	input  logic               arstN,
	input  logic               instrValid,
	input  logic [INSTR_W-1:0] instr,
	input  logic               debugActive,
	input  argT                debugArg,
	input  sel2T               debugBusSeq,
	input  sel2T               debugCcReg,
	input  sel3T               debugPcNext,
	input  seqT                debugRegSeq,
	input  sel2T               intCcReg,
	input  sel3T               intPcNext,
	output groupT              group,
	output aluOpT              opcode,
	output argT                argB,
	output logic [3:0]         mode,
	output logic               dbgActive,
	output argT                dbgArg,
	output sel2T               dbgBusSeq,
	output sel2T               dbgCcReg,
	output sel3T               dbgPcNext,
	output seqT                dbgRegSeq,
	output sel2T               irqCcReg,
	output sel3T               irqPcNext,
	output logic               stageValid
);

	instrT instrQ;

	// Held instruction, upper bits of a wider word
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instrQ <= '0;  // Decodes as a system instruction
		end else if (instrValid) begin
			instrQ <= instr[INSTR_W-1 -: $bits(instrT)];
		end
	end

	// Debug and interrupt fields follow their inputs every cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dbgActive  <= 1'b0;
			dbgArg     <= '0;
			dbgBusSeq  <= BUS_SEQX_NONE;
			dbgCcReg   <= '0;
			dbgPcNext  <= '0;
			dbgRegSeq  <= REG_SEQX_NONE;
			irqCcReg   <= '0;
			irqPcNext  <= '0;
			stageValid <= 1'b0;
		end else begin
			dbgActive  <= debugActive;
			dbgArg     <= debugArg;
			dbgBusSeq  <= debugBusSeq;
			dbgCcReg   <= debugCcReg;
			dbgPcNext  <= debugPcNext;
			dbgRegSeq  <= debugRegSeq;
			irqCcReg   <= intCcReg;
			irqPcNext  <= intPcNext;
			stageValid <= instrValid;
		end
	end

	assign group  = instrQ[15:14];
	assign opcode = instrQ[13:10];
	assign argB   = instrQ[7:4];
	assign mode   = instrQ[3:0];

endmodule

// ==== verilog/aluGroupExec.sv ====
`timescale 1ns/1ps

module aluGroupExec import cpuCtrlPkg::*; (
	input  aluOpT       opcode,
	input  logic [3:0]  mode,
	ctrlFieldsIf.src    fields
);

	logic immOperand;
	logic isMov;
	logic isCmp;

	assign immOperand = mode[3];  // Second operand from the immediate
	assign isMov      = (opcode == ALU_OPX_MOV);
	assign isCmp      = (opcode == ALU_OPX_CMP);

	// Opcode goes straight to the ALU
	assign fields.aluOp   = opcode;
	assign fields.aluaSrc = ALUA_SRCX_REG_A;
	assign fields.alubSrc = immOperand ? ALUB_SRCX_IMM : ALUB_SRCX_REG_B;

	// MOV leaves the flags alone
	assign fields.cclLd = !isMov;

	// Compare only sets flags, no write-back
	assign fields.regSeq = isCmp ? REG_SEQX_NONE : REG_SEQX_WRITE_A;

	assign fields.regaAddr = REGA_ADDRX_ARGA;
	assign fields.regbAddr = REGB_ADDRX_ARGB;
	assign fields.regaDin  = REGA_DINX_ALU_R;
	assign fields.dataBus  = DATA_BUSX_ALU_R;

	// No bus traffic, PC steps to the next word
	assign fields.addrBus  = ADDR_BUSX_PC_A;
	assign fields.busSeq   = BUS_SEQX_NONE;
	assign fields.byteX    = BYTEX_WORD;
	assign fields.pcBase   = PC_BASEX_PC_A;
	assign fields.pcOffset = PC_OFFSETX_2;

endmodule

// ==== verilog/memJumpExec.sv ====
`timescale 1ns/1ps

module memJumpExec import cpuCtrlPkg::*; (
	input  groupT       group,
	input  aluOpT       opcode,
	input  logic [3:0]  mode,
	ctrlFieldsIf.src    fields
);

	logic isJump;
	logic isStore;
	logic isCall;

	assign isJump  = (group == GROUP_JUMP);  // Anything else is treated as load-store
	assign isStore = opcode[0];
	assign isCall  = opcode[2];

	always_comb begin
		// Start from the system defaults
		fields.addrBus  = ADDR_BUSX_PC_A;
		fields.aluOp    = ALU_OPX_MOV;
		fields.aluaSrc  = ALUA_SRCX_REG_A;
		fields.alubSrc  = ALUB_SRCX_REG_B;
		fields.busSeq   = BUS_SEQX_NONE;
		fields.byteX    = BYTEX_WORD;
		fields.cclLd    = 1'b0;
		fields.dataBus  = DATA_BUSX_REGA_DOUT;
		fields.pcBase   = PC_BASEX_PC_A;
		fields.pcOffset = PC_OFFSETX_2;
		fields.regSeq   = REG_SEQX_NONE;
		fields.regaAddr = REGA_ADDRX_ARGA;
		fields.regaDin  = REGA_DINX_DIN;
		fields.regbAddr = REGB_ADDRX_ARGB;

		if (isJump) begin
			// Target is base plus offset
			fields.pcBase   = opcode[1] ? PC_BASEX_REG_B : PC_BASEX_PC_A;
			fields.pcOffset = opcode[0] ? PC_OFFSETX_IMM : PC_OFFSETX_2;

			// Call saves the return address in reg A
			if (isCall) begin
				fields.regSeq  = REG_SEQX_WRITE_A;
				fields.regaDin = REGA_DINX_PC;
			end
		end else begin
			// Address always from reg B
			fields.addrBus = ADDR_BUSX_REG_B;
			fields.byteX   = mode[0];  // Byte access

			if (isStore) begin
				fields.busSeq = BUS_SEQX_WRITE;
				fields.regSeq = REG_SEQX_READ_AB;  // Address and data out of the file
			end else begin
				fields.busSeq = BUS_SEQX_READ;
				fields.regSeq = REG_SEQX_WRITE_A;
			end
		end
	end

endmodule

// ==== verilog/opxMultiplexer.sv ====
`timescale 1ns/1ps

module opxMultiplexer import cpuCtrlPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  groupT      group,
	input  argT        argB,
	input  logic       stageValid,
	input  logic       dbgActive,
	input  argT        dbgArg,
	input  sel2T       dbgBusSeq,
	input  sel2T       dbgCcReg,
	input  sel3T       dbgPcNext,
	input  seqT        dbgRegSeq,
	input  sel2T       irqCcReg,
	input  sel3T       irqPcNext,
	ctrlFieldsIf.sink  aluFields,
	ctrlFieldsIf.sink  memJumpFields,
	output sel3T       addrBus,
	output aluOpT      aluOp,
	output sel3T       aluaSrc,
	output sel3T       alubSrc,
	output argT        argbX,
	output sel2T       busSeq,
	output logic       byteX,
	output logic       cclLd,
	output sel2T       ccReg,
	output sel2T       dataBus,
	output sel2T       pcBase,
	output sel3T       pcNext,
	output sel2T       pcOffset,
	output seqT        regSeq,
	output sel2T       regaAddr,
	output sel2T       regaDin,
	output sel3T       regbAddr,
	output logic       ctrlValid
);

	typedef struct packed {
		sel3T  addrBus;
		aluOpT aluOp;
		sel3T  aluaSrc;
		sel3T  alubSrc;
		argT   argbX;
		sel2T  busSeq;
		logic  byteX;
		logic  cclLd;
		sel2T  ccReg;
		sel2T  dataBus;
		sel2T  pcBase;
		sel3T  pcNext;
		sel2T  pcOffset;
		seqT   regSeq;
		sel2T  regaAddr;
		sel2T  regaDin;
		sel3T  regbAddr;
	} ctrlWordT;

	// System group word, also the base of the debug set
	localparam ctrlWordT SYS_DEFAULTS = '{
		addrBus:  ADDR_BUSX_PC_A,
		aluOp:    ALU_OPX_MOV,
		aluaSrc:  ALUA_SRCX_REG_A,
		alubSrc:  ALUB_SRCX_REG_B,
		argbX:    '0,
		busSeq:   BUS_SEQX_NONE,
		byteX:    BYTEX_WORD,
		cclLd:    1'b0,
		ccReg:    '0,
		dataBus:  DATA_BUSX_REGA_DOUT,
		pcBase:   PC_BASEX_PC_A,
		pcNext:   '0,
		pcOffset: PC_OFFSETX_2,
		regSeq:   REG_SEQX_NONE,
		regaAddr: REGA_ADDRX_ARGA,
		regaDin:  REGA_DINX_DIN,
		regbAddr: REGB_ADDRX_ARGB
	};

	ctrlWordT nextW;
	ctrlWordT ctrlW;

	always_comb begin
		nextW = SYS_DEFAULTS;
		if (dbgActive) begin
			// Debug port owns the bus and the sequencers
			nextW.addrBus = ADDR_BUSX_DEBUG;
			nextW.argbX   = dbgArg;
			nextW.busSeq  = dbgBusSeq;
			nextW.ccReg   = dbgCcReg;
			nextW.pcNext  = dbgPcNext;
			nextW.regSeq  = dbgRegSeq;
		end else begin
			nextW.argbX  = argB;
			nextW.ccReg  = irqCcReg;   // Interrupt block steers flags and PC
			nextW.pcNext = irqPcNext;
			case (group)
				GROUP_LOAD_STORE, GROUP_JUMP: begin
					nextW.addrBus  = memJumpFields.addrBus;
					nextW.aluOp    = memJumpFields.aluOp;
					nextW.aluaSrc  = memJumpFields.aluaSrc;
					nextW.alubSrc  = memJumpFields.alubSrc;
					nextW.busSeq   = memJumpFields.busSeq;
					nextW.byteX    = memJumpFields.byteX;
					nextW.cclLd    = memJumpFields.cclLd;
					nextW.dataBus  = memJumpFields.dataBus;
					nextW.pcBase   = memJumpFields.pcBase;
					nextW.pcOffset = memJumpFields.pcOffset;
					nextW.regSeq   = memJumpFields.regSeq;
					nextW.regaAddr = memJumpFields.regaAddr;
					nextW.regaDin  = memJumpFields.regaDin;
					nextW.regbAddr = memJumpFields.regbAddr;
				end
				GROUP_ARITHMETIC_LOGIC: begin
					nextW.addrBus  = aluFields.addrBus;
					nextW.aluOp    = aluFields.aluOp;
					nextW.aluaSrc  = aluFields.aluaSrc;
					nextW.alubSrc  = aluFields.alubSrc;
					nextW.busSeq   = aluFields.busSeq;
					nextW.byteX    = aluFields.byteX;
					nextW.cclLd    = aluFields.cclLd;
					nextW.dataBus  = aluFields.dataBus;
					nextW.pcBase   = aluFields.pcBase;
					nextW.pcOffset = aluFields.pcOffset;
					nextW.regSeq   = aluFields.regSeq;
					nextW.regaAddr = aluFields.regaAddr;
					nextW.regaDin  = aluFields.regaDin;
					nextW.regbAddr = aluFields.regbAddr;
				end
				default: ;  // System group keeps the defaults
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrlW     <= SYS_DEFAULTS;
			ctrlValid <= 1'b0;
		end else begin
			ctrlW     <= nextW;
			ctrlValid <= stageValid;  // High one cycle per decoded strobe
		end
	end

	assign addrBus  = ctrlW.addrBus;
	assign aluOp    = ctrlW.aluOp;
	assign aluaSrc  = ctrlW.aluaSrc;
	assign alubSrc  = ctrlW.alubSrc;
	assign argbX    = ctrlW.argbX;
	assign busSeq   = ctrlW.busSeq;
	assign byteX    = ctrlW.byteX;
	assign cclLd    = ctrlW.cclLd;
	assign ccReg    = ctrlW.ccReg;
	assign dataBus  = ctrlW.dataBus;
	assign pcBase   = ctrlW.pcBase;
	assign pcNext   = ctrlW.pcNext;
	assign pcOffset = ctrlW.pcOffset;
	assign regSeq   = ctrlW.regSeq;
	assign regaAddr = ctrlW.regaAddr;
	assign regaDin  = ctrlW.regaDin;
	assign regbAddr = ctrlW.regbAddr;

endmodule

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import cpuCtrlPkg::*; #(
	parameter int INSTR_W = 16
) (
	input  logic               clk,
	input  logic               arstN,
	input  logic               instrValid,
	input  logic [INSTR_W-1:0] instr,
	input  logic               debugActive,
	input  argT                debugArg,
	input  sel2T               debugBusSeq,
	input  sel2T               debugCcReg,
	input  sel3T               debugPcNext,
	input  seqT                debugRegSeq,
	input  sel2T               intCcReg,
	input  sel3T               intPcNext,
	output sel3T               addrBus,
	output aluOpT              aluOp,
	output sel3T               aluaSrc,
	output sel3T               alubSrc,
	output argT                argbX,
	output sel2T               busSeq,
	output logic               byteX,
	output logic               cclLd,
	output sel2T               ccReg,
	output sel2T               dataBus,
	output sel2T               pcBase,
	output sel3T               pcNext,
	output sel2T               pcOffset,
	output seqT                regSeq,
	output sel2T               regaAddr,
	output sel2T               regaDin,
	output sel3T               regbAddr,
	output logic               ctrlValid
);

	// Decode stage outputs
	groupT      group;
	aluOpT      opcode;
	argT        argB;
	logic [3:0] mode;
	logic       dbgActive;
	argT        dbgArg;
	sel2T       dbgBusSeq;
	sel2T       dbgCcReg;
	sel3T       dbgPcNext;
	seqT        dbgRegSeq;
	sel2T       irqCcReg;
	sel3T       irqPcNext;
	logic       stageValid;

	ctrlFieldsIf aluFields ();
	ctrlFieldsIf memJumpFields ();

	instrDecode #(.INSTR_W(INSTR_W)) decode (
		.clk, .arstN, .instrValid, .instr,
		.debugActive, .debugArg, .debugBusSeq, .debugCcReg, .debugPcNext, .debugRegSeq,
		.intCcReg, .intPcNext,
		.group, .opcode, .argB, .mode,
		.dbgActive, .dbgArg, .dbgBusSeq, .dbgCcReg, .dbgPcNext, .dbgRegSeq,
		.irqCcReg, .irqPcNext, .stageValid
	);

	aluGroupExec aluExec (
		.opcode, .mode,
		.fields(aluFields)
	);

	memJumpExec memJumpExecU (
		.group, .opcode, .mode,
		.fields(memJumpFields)
	);

	opxMultiplexer resultMux (
		.clk, .arstN, .group, .argB, .stageValid,
		.dbgActive, .dbgArg, .dbgBusSeq, .dbgCcReg, .dbgPcNext, .dbgRegSeq,
		.irqCcReg, .irqPcNext,
		.aluFields(aluFields),
		.memJumpFields(memJumpFields),
		.addrBus, .aluOp, .aluaSrc, .alubSrc, .argbX, .busSeq, .byteX, .cclLd,
		.ccReg, .dataBus, .pcBase, .pcNext, .pcOffset, .regSeq,
		.regaAddr, .regaDin, .regbAddr, .ctrlValid
	);

endmodule

// ==== testbench/controlUnitAssertions.sv ====
`timescale 1ns/1ps

module controlUnitAssertions import cpuCtrlPkg::*; (
	input logic  clk,
	input logic  arstN,
	input logic  instrValid,
	input groupT group,
	input logic  dbgActive,
	input logic  cclLd,
	input sel3T  addrBus,
	input logic  ctrlValid
);

	// Flags load only for an arithmetic-logic word outside debug
	cclLdAluOnly: assert property (@(posedge clk) disable iff (!arstN)
		cclLd |-> ($past(group) == GROUP_ARITHMETIC_LOGIC && !$past(dbgActive)))
		else $error("cclLd high outside the arithmetic-logic group");

	addrBusDebug: assert property (@(posedge clk) disable iff (!arstN)
		(addrBus == ADDR_BUSX_DEBUG) == $past(dbgActive))  // Debug owns the bus
		else $error("address bus debug select does not match debug request");

	// Strobe passes the decode and result registers
	ctrlValidPulse: assert property (@(posedge clk) disable iff (!arstN)
		ctrlValid == $past(instrValid, 2))
		else $error("ctrlValid is not one cycle per instruction strobe");

endmodule

bind controlUnit controlUnitAssertions resultChecks (
	.clk, .arstN, .instrValid, .group, .dbgActive, .cclLd, .addrBus, .ctrlValid
);

// ==== testbench/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb import cpuCtrlPkg::*; ();

	localparam int WAIT_LIMIT = 20;

	typedef struct packed {
		sel3T  addrBus;
		aluOpT aluOp;
		sel3T  aluaSrc;
		sel3T  alubSrc;
		argT   argbX;
		sel2T  busSeq;
		logic  byteX;
		logic  cclLd;
		sel2T  ccReg;
		sel2T  dataBus;
		sel2T  pcBase;
		sel3T  pcNext;
		sel2T  pcOffset;
		seqT   regSeq;
		sel2T  regaAddr;
		sel2T  regaDin;
		sel3T  regbAddr;
	} ctrlWordT;

	logic clk = 1'b0;
	logic arstN;
	logic instrValid;
	instrT instr;
	logic debugActive;
	argT debugArg;
	sel2T debugBusSeq;
	sel2T debugCcReg;
	sel3T debugPcNext;
	seqT debugRegSeq;
	sel2T intCcReg;
	sel3T intPcNext;
	wire ctrlWordT dutW;
	logic ctrlValid;

	int errors = 0;
	int timeouts = 0;
	logic [31:0] lfsrState = 32'h2590_ccc9;

	always #50 clk = ~clk;

	controlUnit #(.INSTR_W(16)) UUT (
		.clk, .arstN, .instrValid, .instr,
		.debugActive, .debugArg, .debugBusSeq, .debugCcReg, .debugPcNext, .debugRegSeq,
		.intCcReg, .intPcNext,
		.addrBus(dutW.addrBus), .aluOp(dutW.aluOp), .aluaSrc(dutW.aluaSrc),
		.alubSrc(dutW.alubSrc), .argbX(dutW.argbX), .busSeq(dutW.busSeq),
		.byteX(dutW.byteX), .cclLd(dutW.cclLd), .ccReg(dutW.ccReg),
		.dataBus(dutW.dataBus), .pcBase(dutW.pcBase), .pcNext(dutW.pcNext),
		.pcOffset(dutW.pcOffset), .regSeq(dutW.regSeq), .regaAddr(dutW.regaAddr),
		.regaDin(dutW.regaDin), .regbAddr(dutW.regbAddr), .ctrlValid
	);

	// Galois form with taps 32 31 29 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Expected control word from the debug and interrupt inputs as currently driven
	function automatic ctrlWordT expectedWord(input instrT i);
		ctrlWordT w;
		groupT g;
		aluOpT op;
		g = i[15:14];
		op = i[13:10];
		w.addrBus  = ADDR_BUSX_PC_A;
		w.aluOp    = ALU_OPX_MOV;
		w.aluaSrc  = ALUA_SRCX_REG_A;
		w.alubSrc  = ALUB_SRCX_REG_B;
		w.argbX    = '0;
		w.busSeq   = BUS_SEQX_NONE;
		w.byteX    = BYTEX_WORD;
		w.cclLd    = 1'b0;
		w.ccReg    = '0;
		w.dataBus  = DATA_BUSX_REGA_DOUT;
		w.pcBase   = PC_BASEX_PC_A;
		w.pcNext   = '0;
		w.pcOffset = PC_OFFSETX_2;
		w.regSeq   = REG_SEQX_NONE;
		w.regaAddr = REGA_ADDRX_ARGA;
		w.regaDin  = REGA_DINX_DIN;
		w.regbAddr = REGB_ADDRX_ARGB;
		if (debugActive) begin
			w.addrBus = ADDR_BUSX_DEBUG;
			w.argbX   = debugArg;
			w.busSeq  = debugBusSeq;
			w.ccReg   = debugCcReg;
			w.pcNext  = debugPcNext;
			w.regSeq  = debugRegSeq;
		end else begin
			w.argbX  = i[7:4];
			w.ccReg  = intCcReg;
			w.pcNext = intPcNext;
			if (g == GROUP_ARITHMETIC_LOGIC) begin
				w.aluOp   = op;
				w.alubSrc = i[3] ? ALUB_SRCX_IMM : ALUB_SRCX_REG_B;
				w.cclLd   = (op != ALU_OPX_MOV);
				w.regSeq  = (op == ALU_OPX_CMP) ? REG_SEQX_NONE : REG_SEQX_WRITE_A;
				w.dataBus = DATA_BUSX_ALU_R;
				w.regaDin = REGA_DINX_ALU_R;
			end else if (g == GROUP_LOAD_STORE) begin
				w.addrBus = ADDR_BUSX_REG_B;
				w.byteX   = i[0];
				w.busSeq  = op[0] ? BUS_SEQX_WRITE : BUS_SEQX_READ;  // Bit 0 means store
				w.regSeq  = op[0] ? REG_SEQX_READ_AB : REG_SEQX_WRITE_A;
			end else if (g == GROUP_JUMP) begin
				w.pcBase   = op[1] ? PC_BASEX_REG_B : PC_BASEX_PC_A;
				w.pcOffset = op[0] ? PC_OFFSETX_IMM : PC_OFFSETX_2;
				if (op[2]) begin  // Call
					w.regSeq  = REG_SEQX_WRITE_A;
					w.regaDin = REGA_DINX_PC;
				end
			end
		end
		return w;
	endfunction

	task automatic checkSel2(input string t, input string f, input sel2T e, input sel2T a);
		if (e !== a) begin
			$display("ERR %s %s: expected %0h, actual %0h", t, f, e, a);
			errors++;
		end
	endtask

	task automatic checkSel3(input string t, input string f, input sel3T e, input sel3T a);
		if (e !== a) begin
			$display("ERR %s %s: expected %0h, actual %0h", t, f, e, a);
			errors++;
		end
	endtask

	task automatic checkSeq(input string t, input string f, input seqT e, input seqT a);
		if (e !== a) begin
			$display("ERR %s %s: expected %0h, actual %0h", t, f, e, a);
			errors++;
		end
	endtask

	task automatic checkArg(input string t, input string f, input argT e, input argT a);
		if (e !== a) begin
			$display("ERR %s %s: expected %0h, actual %0h", t, f, e, a);
			errors++;
		end
	endtask

	task automatic checkAluOp(input string t, input string f, input aluOpT e, input aluOpT a);
		if (e !== a) begin
			$display("ERR %s %s: expected %0h, actual %0h", t, f, e, a);
			errors++;
		end
	endtask

	task automatic checkBit(input string t, input string f, input logic e, input logic a);
		if (e !== a) begin
			$display("ERR %s %s: expected %0b, actual %0b", t, f, e, a);
			errors++;
		end
	endtask

	task automatic compareAll(input string t, input ctrlWordT e, input ctrlWordT a);
		checkSel3(t, "addrBus", e.addrBus, a.addrBus);
		checkAluOp(t, "aluOp", e.aluOp, a.aluOp);
		checkSel3(t, "aluaSrc", e.aluaSrc, a.aluaSrc);
		checkSel3(t, "alubSrc", e.alubSrc, a.alubSrc);
		checkArg(t, "argbX", e.argbX, a.argbX);
		checkSel2(t, "busSeq", e.busSeq, a.busSeq);
		checkBit(t, "byteX", e.byteX, a.byteX);
		checkBit(t, "cclLd", e.cclLd, a.cclLd);
		checkSel2(t, "ccReg", e.ccReg, a.ccReg);
		checkSel2(t, "dataBus", e.dataBus, a.dataBus);
		checkSel2(t, "pcBase", e.pcBase, a.pcBase);
		checkSel3(t, "pcNext", e.pcNext, a.pcNext);
		checkSel2(t, "pcOffset", e.pcOffset, a.pcOffset);
		checkSeq(t, "regSeq", e.regSeq, a.regSeq);
		checkSel2(t, "regaAddr", e.regaAddr, a.regaAddr);
		checkSel2(t, "regaDin", e.regaDin, a.regaDin);
		checkSel3(t, "regbAddr", e.regbAddr, a.regbAddr);
	endtask

	task automatic waitValid(input string t, output logic seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clk);  // Outputs settled
			cycles++;
			seen = ctrlValid;
		end
		if (!seen) begin
			$display("Timeout in %s: ctrlValid did not rise within %0d cycles", t, WAIT_LIMIT);
			timeouts++;
		end
	endtask

	// One strobe with new interrupt fields
	task automatic runInstr(input string t, input instrT i, input sel2T cc, input sel3T pc);
		logic seen;
		@(posedge clk);
		instr <= i;
		instrValid <= 1'b1;
		intCcReg <= cc;
		intPcNext <= pc;
		@(posedge clk);
		instrValid <= 1'b0;
		waitValid(t, seen);
		if (seen) begin
			compareAll(t, expectedWord(i), dutW);
		end
	endtask

	task automatic resetDefaults();
		repeat (2) @(negedge clk);
		checkBit("reset", "ctrlValid", 1'b0, ctrlValid);
		compareAll("reset", expectedWord('0), dutW);
	endtask

	task automatic aluGroupInstrs();
		aluOpT op;
		logic [9:0] low;
		for (int k = 0; k < 40; k++) begin
			op = aluOpT'(randBits(4));
			low = 10'(randBits(10));
			if (k == 0) op = ALU_OPX_MOV;
			if (k == 1) op = ALU_OPX_CMP;
			if (k == 2) low[3] = 1'b1;  // Immediate operand
			runInstr($sformatf("alu[%0d]", k), {GROUP_ARITHMETIC_LOGIC, op, low},
				sel2T'(randBits(2)), sel3T'(randBits(3)));
		end
	endtask

	task automatic loadStoreInstrs();
		aluOpT op;
		for (int k = 0; k < 16; k++) begin
			op = aluOpT'(randBits(4));
			if (k < 2) op[0] = k[0];  // One load and one store for sure
			runInstr($sformatf("loadStore[%0d]", k), {GROUP_LOAD_STORE, op, 10'(randBits(10))},
				sel2T'(randBits(2)), sel3T'(randBits(3)));
		end
	endtask

	task automatic jumpInstrs();
		for (int k = 0; k < 8; k++) begin
			runInstr($sformatf("jump[%0d]", k), {GROUP_JUMP, aluOpT'(k), 10'(randBits(10))},
				sel2T'(randBits(2)), sel3T'(randBits(3)));
		end
	endtask

	task automatic debugAndSystem();
		for (int k = 0; k < 6; k++) begin
			@(posedge clk);
			debugActive <= 1'b1;
			debugArg <= argT'(randBits(4));
			debugBusSeq <= sel2T'(randBits(2));
			debugCcReg <= sel2T'(randBits(2));
			debugPcNext <= sel3T'(randBits(3));
			debugRegSeq <= seqT'(randBits(4));
			runInstr($sformatf("debug[%0d]", k), instrT'(randBits(16)),
				sel2T'(randBits(2)), sel3T'(randBits(3)));
		end
		@(posedge clk);
		debugActive <= 1'b0;
		for (int k = 0; k < 6; k++) begin
			runInstr($sformatf("system[%0d]", k), {GROUP_SYSTEM, 14'(randBits(14))},
				sel2T'(randBits(2)), sel3T'(randBits(3)));
		end
	endtask

	// Strobe every cycle and check each word two edges after it is driven
	task automatic backToBackStrobes();
		instrT q[$];
		for (int k = 0; k < 8; k++) begin
			q.push_back(instrT'(randBits(16)));
		end
		for (int k = 0; k < 10; k++) begin
			@(posedge clk);
			if (k < 8) begin
				instr <= q[k];
				instrValid <= 1'b1;
			end else begin
				instrValid <= 1'b0;
			end
			@(negedge clk);
			if (k >= 2) begin
				checkBit($sformatf("backToBack[%0d]", k - 2), "ctrlValid", 1'b1, ctrlValid);
				compareAll($sformatf("backToBack[%0d]", k - 2), expectedWord(q[k - 2]), dutW);
			end
		end
	endtask

	initial begin
		arstN <= 1'b0;
		instrValid <= 1'b0;
		instr <= '0;
		debugActive <= 1'b0;
		debugArg <= '0;
		debugBusSeq <= BUS_SEQX_NONE;
		debugCcReg <= '0;
		debugPcNext <= '0;
		debugRegSeq <= REG_SEQX_NONE;
		intCcReg <= '0;
		intPcNext <= '0;
		repeat (16) @(posedge clk);
		arstN <= 1'b1;

		resetDefaults();
		aluGroupInstrs();
		loadStoreInstrs();
		jumpInstrs();
		debugAndSystem();
		backToBackStrobes();

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== src.f ====
verilog/cpuCtrlPkg.sv
verilog/ctrlFieldsIf.sv
verilog/instrDecode.sv
verilog/aluGroupExec.sv
verilog/memJumpExec.sv
verilog/opxMultiplexer.sv
verilog/controlUnit.sv
testbench/controlUnitAssertions.sv
testbench/controlUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module controlUnitTb -f src.f -o simv

output="$(./obj_dir/simv 2>&1)"
echo "$output"

if grep -q "^STATUS: PASS$" <<< "$output"; then
	exit 0
else
	exit 1
fi
